/* src/i2c_cfg.svh */
`ifndef I2C_CFG_SVH
`define I2C_CFG_SVH

////////////////////////////////////////
// bus timing, in clk cycles
////////////////////////////////////////

`define I2C_SCL_PERIOD  250     // one scl period
`define I2C_SCL_HALF    125     // scl rises here
`define I2C_SDA_CHANGE  61      // sda may change, scl low
`define I2C_SDA_SAMPLE  191     // sda sampled, start/stop edges

////////////////////////////////////////
// field widths and fixed values
////////////////////////////////////////

`define I2C_DEV_BASE    4'b1010 // upper nibble of the device address
`define I2C_REG_AW      11
`define AXIL_DW         32

`endif

/* src/i2c_pkg.sv */
`include "i2c_cfg.svh"

package i2c_pkg;

    ////////////////////////////////////////
    // enums
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_BYTE,
        ST_STOP
    } wr_state_e;

    // byte order on the wire
    typedef enum logic [1:0] {
        SEL_DEV,
        SEL_REG_HI,
        SEL_REG_LO,
        SEL_DATA
    } byte_sel_e;

    ////////////////////////////////////////
    // structs
    ////////////////////////////////////////

    typedef struct packed {
        logic                   awvalid;
        logic [`I2C_REG_AW-1:0] awaddr;
        logic                   wvalid;
        logic [`AXIL_DW-1:0]    wdata;
        logic                   bready;
    } axil_wr_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
    } axil_wr_rsp_t;

    typedef struct packed {
        logic [6:0]             dev_addr;   // base nibble + board bits
        logic [`I2C_REG_AW-1:0] reg_addr;
        logic [7:0]             data;
    } i2c_cmd_t;

    // single-cycle pulses from the scl timer
    typedef struct packed {
        logic change;
        logic sample;
        logic period_end;
    } scl_tick_t;

endpackage

/* src/axil_cmd_port.sv */
`include "i2c_cfg.svh"

module axil_cmd_port (
    input  logic                 clk,
    input  logic                 rst_n,
    input  i2c_pkg::axil_wr_req_t req,
    output i2c_pkg::axil_wr_rsp_t rsp,
    input  logic [2:0]           addr_bits,
    output logic                 cmd_valid,
    output i2c_pkg::i2c_cmd_t    cmd,
    input  logic                 cmd_done,
    input  logic                 nack
);
    import i2c_pkg::*;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic       busy;       // command handed to the i2c side
    logic       bvalid_q;
    logic [1:0] bresp_q;
    logic       accept;
    i2c_cmd_t   cmd_q;

    // both channels at once with nothing in flight and no response waiting
    assign accept = !busy && !bvalid_q && req.awvalid && req.wvalid;

    ////////////////////////////////////////
    // command register
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            cmd_q.dev_addr <= {`I2C_DEV_BASE, addr_bits};
            cmd_q.reg_addr <= req.awaddr[`I2C_REG_AW-1:0];
            cmd_q.data     <= req.wdata[7:0];   // upper data bits ignored
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy <= 1'b0;
        end
        else if (accept)
        begin
            busy <= 1'b1;
        end
        else if (cmd_done)
        begin
            busy <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // write response
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bvalid_q <= 1'b0;
            bresp_q  <= RESP_OKAY;
        end
        else if (cmd_done)
        begin
            bvalid_q <= 1'b1;
            bresp_q  <= nack ? RESP_SLVERR : RESP_OKAY;
        end
        else if (bvalid_q && req.bready)
        begin
            bvalid_q <= 1'b0;   // bresp stays until the next done
        end
    end

    always_comb
    begin
        rsp.awready = accept;
        rsp.wready  = accept;
        rsp.bvalid  = bvalid_q;
        rsp.bresp   = bresp_q;
    end

    assign cmd_valid = busy && !cmd_done;   // withdrawn while the fsm is already idle
    assign cmd       = cmd_q;

endmodule

/* src/scl_timer.sv */
`include "i2c_cfg.svh"

module scl_timer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               run,
    input  logic               hold_high,
    output logic               scl,
    output i2c_pkg::scl_tick_t tick
);
    localparam int CNT_W = $clog2(`I2C_SCL_PERIOD);

    logic [CNT_W-1:0] cnt;
    logic             armed;    // at least one period done in this run
    logic             last;

    assign last = (cnt == CNT_W'(`I2C_SCL_PERIOD - 1));

    // modulo-period counter, parked at zero while idle
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt <= '0;
        end
        else if (!run || last)
        begin
            cnt <= '0;
        end
        else
        begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            armed <= 1'b0;
        end
        else if (!run)
        begin
            armed <= 1'b0;
        end
        else if (last)
        begin
            armed <= 1'b1;
        end
    end

    // first hold period keeps scl high straight out of idle,
    // a later one (stop) gets its low half like a data bit
    assign scl = !run
               || (cnt >= CNT_W'(`I2C_SCL_HALF))
               || (hold_high && !armed);

    assign tick.change     = run && (cnt == CNT_W'(`I2C_SDA_CHANGE));
    assign tick.sample     = run && (cnt == CNT_W'(`I2C_SDA_SAMPLE));
    assign tick.period_end = run && last;

endmodule

/* src/byte_shifter.sv */
`include "i2c_cfg.svh"

module byte_shifter (
    input  logic               clk,
    input  logic               rst_n,
    input  i2c_pkg::scl_tick_t tick,
    input  logic               load,
    input  i2c_pkg::byte_sel_e sel,
    input  i2c_pkg::i2c_cmd_t  cmd,
    input  logic               sda_in,
    output logic               bit_oe,
    output logic               byte_done,
    output logic               ack_ok
);
    import i2c_pkg::*;

    logic [7:0] byte_val;
    logic [7:0] sh;         // msb goes out next
    logic [3:0] bit_cnt;    // data bits sent, 9 once ack slot opened
    logic       active;
    logic       oe_q;
    logic       ack_q;
    logic       done_q;

    // byte formatting
    always_comb
    begin
        case (sel)
            SEL_DEV:    byte_val = {cmd.dev_addr, 1'b0};    // write bit
            SEL_REG_HI: byte_val = cmd.reg_addr[`I2C_REG_AW-1 -: 8];
            SEL_REG_LO: byte_val = {cmd.reg_addr[2:0], 5'b11111};
            default:    byte_val = cmd.data;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (load)
            sh <= byte_val;
        else if (active && tick.change && (bit_cnt < 4'd8))
            sh <= {sh[6:0], 1'b1};
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bit_cnt <= '0;
            active  <= 1'b0;
            oe_q    <= 1'b0;
            ack_q   <= 1'b0;
            done_q  <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            if (load)
            begin
                bit_cnt <= '0;
                active  <= 1'b1;
                oe_q    <= 1'b1;    // keep sda low until the first change point
            end
            else if (active && tick.change)
            begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt < 4'd8)
                    oe_q <= ~sh[7];     // low bit pulls the line
                else
                    oe_q <= 1'b0;       // release for ack
            end
            else if (active && tick.sample && (bit_cnt == 4'd9))
            begin
                ack_q  <= ~sda_in;  // slave holds sda low to ack
                done_q <= 1'b1;
                active <= 1'b0;
            end
        end
    end

    assign bit_oe    = oe_q;
    assign byte_done = done_q;
    assign ack_ok    = ack_q;

endmodule

/* src/i2c_write_fsm.sv */
module i2c_write_fsm (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cmd_valid,
    input  i2c_pkg::scl_tick_t  tick,
    input  logic                byte_done,
    input  logic                ack_ok,
    input  logic                bit_oe,
    output logic                run,
    output logic                hold_high,
    output logic                shift_load,
    output i2c_pkg::byte_sel_e  sel,
    output logic                sda_oe,
    output logic                cmd_done,
    output logic                nack
);
    import i2c_pkg::*;

    wr_state_e state;
    byte_sel_e sel_q;       // byte currently on the wire
    logic      line_oe;     // sda pull during start and stop
    logic      byte_ended;  // ack of the current byte seen
    logic      nack_q;
    logic      done_q;
    logic      more;

    function automatic byte_sel_e next_sel(input byte_sel_e cur);
        case (cur)
            SEL_DEV:    return SEL_REG_HI;
            SEL_REG_HI: return SEL_REG_LO;
            SEL_REG_LO: return SEL_DATA;
            default:    return SEL_DEV;
        endcase
    endfunction

    // another byte follows the current one
    assign more = byte_ended && !nack_q && (sel_q != SEL_DATA);

    assign shift_load = tick.period_end
                      && ((state == ST_START) || ((state == ST_BYTE) && more));
    assign sel        = (state == ST_START) ? SEL_DEV : next_sel(sel_q);

    ////////////////////////////////////////
    // transaction sequencing
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= ST_IDLE;
            sel_q      <= SEL_DEV;
            line_oe    <= 1'b0;
            byte_ended <= 1'b0;
            nack_q     <= 1'b0;
            done_q     <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (cmd_valid)
                    begin
                        state  <= ST_START;
                        nack_q <= 1'b0;
                    end
                end
                ST_START:
                begin
                    if (tick.sample)
                        line_oe <= 1'b1;    // sda falls with scl high
                    if (tick.period_end)
                    begin
                        state      <= ST_BYTE;
                        sel_q      <= SEL_DEV;
                        line_oe    <= 1'b0;
                        byte_ended <= 1'b0;
                    end
                end
                ST_BYTE:
                begin
                    if (byte_done)
                    begin
                        byte_ended <= 1'b1;
                        if (!ack_ok)
                            nack_q <= 1'b1;
                    end
                    if (tick.period_end && byte_ended)
                    begin
                        byte_ended <= 1'b0;
                        if (more)
                            sel_q <= next_sel(sel_q);
                        else
                            state <= ST_STOP;   // last byte or nack
                    end
                end
                ST_STOP:
                begin
                    if (tick.change)
                        line_oe <= 1'b1;
                    else if (tick.sample)
                        line_oe <= 1'b0;    // sda rises with scl high
                    if (tick.period_end)
                    begin
                        state  <= ST_IDLE;
                        done_q <= 1'b1;
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    assign run       = (state != ST_IDLE);
    assign hold_high = (state == ST_START) || (state == ST_STOP);
    assign sda_oe    = (state == ST_BYTE) ? bit_oe : line_oe;
    assign cmd_done  = done_q;
    assign nack      = nack_q;

endmodule

/* src/i2c_reg_writer.sv */
module i2c_reg_writer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  i2c_pkg::axil_wr_req_t axil_req,
    output i2c_pkg::axil_wr_rsp_t axil_rsp,
    input  logic [2:0]            addr_bits,
    output logic                  scl,
    output logic                  sda_oe,   // high pulls sda low
    input  logic                  sda_in
);
    import i2c_pkg::*;

    // host side
    logic      cmd_valid;
    i2c_cmd_t  cmd;
    logic      cmd_done;
    logic      nack;

    // i2c engine
    logic      run;
    logic      hold_high;
    scl_tick_t tick;
    logic      shift_load;
    byte_sel_e sel;
    logic      bit_oe;
    logic      byte_done;
    logic      ack_ok;

    axil_cmd_port u_cmd_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (axil_req),
        .rsp       (axil_rsp),
        .addr_bits (addr_bits),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_done  (cmd_done),
        .nack      (nack)
    );

    scl_timer u_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .hold_high (hold_high),
        .scl       (scl),
        .tick      (tick)
    );

    byte_shifter u_shifter (
        .clk       (clk),
        .rst_n     (rst_n),
        .tick      (tick),
        .load      (shift_load),
        .sel       (sel),
        .cmd       (cmd),
        .sda_in    (sda_in),
        .bit_oe    (bit_oe),
        .byte_done (byte_done),
        .ack_ok    (ack_ok)
    );

    i2c_write_fsm u_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .tick       (tick),
        .byte_done  (byte_done),
        .ack_ok     (ack_ok),
        .bit_oe     (bit_oe),
        .run        (run),
        .hold_high  (hold_high),
        .shift_load (shift_load),
        .sel        (sel),
        .sda_oe     (sda_oe),
        .cmd_done   (cmd_done),
        .nack       (nack)
    );

endmodule

/* tests/i2c_slave_model.sv */
module i2c_slave_model (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            clr,        // clears the record before a transaction
    input  logic [2:0]      nack_at,    // byte index that gets no ack, 4 = none
    input  logic            scl,
    input  logic            master_oe,
    output logic            sda,
    output logic [3:0][7:0] rx_bytes,
    output logic [2:0]      rx_count,
    output logic [3:0]      start_cnt,
    output logic [3:0]      stop_cnt
);
    timeunit 1ns;
    timeprecision 1ps;

    logic       scl_q;
    logic       sda_q;
    logic       in_xfer;
    logic       ack_pull;
    logic [3:0] bit_idx;    // 8 after the last data bit, 9 in the ack slot
    logic [2:0] byte_idx;
    logic [7:0] shreg;

    // open drain line with pull-up
    assign sda = !(master_oe || ack_pull);

    // line values read here are the ones from before the edge
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            in_xfer   <= 1'b0;
            ack_pull  <= 1'b0;
            bit_idx   <= 4'd0;
            byte_idx  <= 3'd0;
            shreg     <= 8'd0;
            rx_bytes  <= '0;
            rx_count  <= 3'd0;
            start_cnt <= 4'd0;
            stop_cnt  <= 4'd0;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (clr)
            begin
                rx_bytes  <= '0;
                rx_count  <= 3'd0;
                start_cnt <= 4'd0;
                stop_cnt  <= 4'd0;
            end
            else if (scl_q && scl && sda_q && !sda)
            begin
                start_cnt <= start_cnt + 4'd1;  // sda falls, scl high
                in_xfer   <= 1'b1;
                bit_idx   <= 4'd0;
                byte_idx  <= 3'd0;
            end
            else if (scl_q && scl && !sda_q && sda)
            begin
                stop_cnt <= stop_cnt + 4'd1;    // sda rises, scl high
                in_xfer  <= 1'b0;
                ack_pull <= 1'b0;
            end
            else if (in_xfer && !scl_q && scl && (bit_idx < 4'd8))
            begin
                shreg   <= {shreg[6:0], sda};
                bit_idx <= bit_idx + 4'd1;
            end
            else if (in_xfer && scl_q && !scl)
            begin
                if (bit_idx == 4'd8)
                begin
                    if (byte_idx < 3'd4)
                    begin
                        rx_bytes[byte_idx[1:0]] <= shreg;
                        rx_count                <= rx_count + 3'd1;
                    end
                    ack_pull <= (byte_idx != nack_at);
                    bit_idx  <= 4'd9;
                end
                else if (bit_idx == 4'd9)
                begin
                    ack_pull <= 1'b0;   // ack slot over
                    bit_idx  <= 4'd0;
                    byte_idx <= byte_idx + 3'd1;
                end
            end
        end
    end

endmodule

/* tests/tb_i2c_reg_writer.sv */
`include "i2c_cfg.svh"

module tb_i2c_reg_writer;
    timeunit 1ns;
    timeprecision 1ps;

    import i2c_pkg::*;

    localparam int CLK_PERIOD = 40;

    // one line of the stimulus file
    typedef struct packed {
        logic [10:0] reg_addr;
        logic [7:0]  data;
        logic [2:0]  addr_bits;
        logic [2:0]  nack_idx;
        logic [1:0]  bresp;
    } stim_t;

    logic            clk;
    logic            rst_n;
    axil_wr_req_t    axil_req;
    axil_wr_rsp_t    axil_rsp;
    logic [2:0]      addr_bits;
    logic            scl;
    logic            sda_oe;
    logic            sda;
    logic            clr;
    logic [2:0]      nack_at;
    logic [3:0][7:0] rx_bytes;
    logic [2:0]      rx_count;
    logic [3:0]      start_cnt;
    logic [3:0]      stop_cnt;

    stim_t           stim_q[$];
    int              mismatches;
    int              failures;
    logic [31:0]     lcg_state;
    bit              stim_ready;

    i2c_reg_writer UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .addr_bits (addr_bits),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda)
    );

    i2c_slave_model slave (
        .clk       (clk),
        .rst_n     (rst_n),
        .clr       (clr),
        .nack_at   (nack_at),
        .scl       (scl),
        .master_oe (sda_oe),
        .sda       (sda),
        .rx_bytes  (rx_bytes),
        .rx_count  (rx_count),
        .start_cnt (start_cnt),
        .stop_cnt  (stop_cnt)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // expected bytes in wire order
    function automatic logic [7:0] expected_byte(input stim_t s, input int idx);
        case (idx)
            0:       return {`I2C_DEV_BASE, s.addr_bits, 1'b0};
            1:       return s.reg_addr[10:3];
            2:       return {s.reg_addr[2:0], 5'b11111};
            default: return s.data;
        endcase
    endfunction

    task automatic show_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        mismatches++;
        $display("MISMATCH at %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
    endtask

    task automatic log_failure(input string what);
        failures++;
        $display("ERROR at %0d ns: %s", $time, what);
    endtask

    task automatic end_run();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        stim_t       s;
        logic [10:0] ra;
        logic [7:0]  dt;
        logic [2:0]  ab;
        logic [2:0]  ni;
        logic [1:0]  br;
        fd = $fopen("tests/i2c_stim.txt", "r");
        if (fd == 0)
        begin
            log_failure("cannot open tests/i2c_stim.txt");
            return;
        end
        while ($fgets(line, fd) > 0)
        begin
            n = $sscanf(line, "%h %h %h %h %h", ra, dt, ab, ni, br);
            if (n == 5)     // comment lines give no fields
            begin
                s.reg_addr  = ra;
                s.data      = dt;
                s.addr_bits = ab;
                s.nack_idx  = ni;
                s.bresp     = br;
                stim_q.push_back(s);
            end
        end
        $fclose(fd);
    endtask

    // bus stays released with scl and sda high for a whole scl period
    task automatic check_idle();
        int n;
        bit seen;
        seen = 0;
        for (n = 0; n < `I2C_SCL_PERIOD && !seen; n++)
        begin
            @(negedge clk);
            if (scl !== 1'b1)
            begin
                show_mismatch("scl", 32'd1, 32'(scl));
                seen = 1;
            end
            if (sda !== 1'b1)
            begin
                show_mismatch("sda", 32'd1, 32'(sda));
                seen = 1;
            end
        end
    endtask

    ////////////////////////////////////////
    // one axi write, one i2c transaction
    ////////////////////////////////////////

    task automatic run_transaction(input stim_t s);
        logic [1:0] bresp_seen;
        logic [7:0] exp_b;
        int         cycles;
        int         stall;
        int         exp_count;
        int         i;
        bit         got_hs;
        bit         got_b;
        exp_count = (s.nack_idx < 3'd4) ? int'(s.nack_idx) + 1 : 4;
        @(posedge clk);
        clr       <= 1'b1;
        nack_at   <= s.nack_idx;
        addr_bits <= s.addr_bits;
        @(posedge clk);
        clr       <= 1'b0;
        lcg_state = lcg_next(lcg_state);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= s.reg_addr;
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= {lcg_state[31:8], s.data};  // upper bits are noise
        axil_req.bready  <= 1'b0;

        got_hs = 0;
        cycles = 0;
        while (!got_hs && cycles < 16)
        begin
            @(negedge clk);
            if (axil_rsp.awready && axil_rsp.wready)
                got_hs = 1;
            else if (axil_rsp.awready || axil_rsp.wready)
                log_failure("awready and wready not raised together");
            cycles++;
        end
        if (!got_hs)
        begin
            log_failure("write handshake not seen");
            return;
        end
        @(posedge clk);
        // a second write waits and must not be taken
        lcg_state = lcg_next(lcg_state);
        axil_req.awaddr <= ~s.reg_addr;
        axil_req.wdata  <= lcg_state;

        got_b  = 0;
        cycles = 0;
        while (!got_b && cycles < 45 * `I2C_SCL_PERIOD)
        begin
            @(negedge clk);
            if (axil_rsp.awready || axil_rsp.wready)
                log_failure("second write accepted while busy");
            if (axil_rsp.bvalid)
                got_b = 1;
            cycles++;
        end
        if (!got_b)
        begin
            log_failure("no write response after the transaction");
            return;
        end
        bresp_seen = axil_rsp.bresp;
        if (bresp_seen !== s.bresp)
            show_mismatch("bresp", 32'(s.bresp), 32'(bresp_seen));

        // response must hold through a bready stall
        lcg_state = lcg_next(lcg_state);
        stall = int'(lcg_state[18:16]);
        repeat (stall)
        begin
            @(negedge clk);
            if (axil_rsp.bvalid !== 1'b1)
                show_mismatch("bvalid", 32'd1, 32'(axil_rsp.bvalid));
            if (axil_rsp.bresp !== bresp_seen)
                show_mismatch("bresp", 32'(bresp_seen), 32'(axil_rsp.bresp));
            if (axil_rsp.awready || axil_rsp.wready)
                log_failure("second write accepted while bvalid pending");
        end
        @(posedge clk);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        axil_req.bready  <= 1'b1;
        @(posedge clk);
        axil_req.bready  <= 1'b0;
        @(negedge clk);
        if (axil_rsp.bvalid !== 1'b0)
            show_mismatch("bvalid", 32'd0, 32'(axil_rsp.bvalid));

        // what the slave saw on the wire
        if (start_cnt !== 4'd1)
            show_mismatch("start_cnt", 32'd1, 32'(start_cnt));
        if (stop_cnt !== 4'd1)
            show_mismatch("stop_cnt", 32'd1, 32'(stop_cnt));
        if (rx_count !== 3'(exp_count))
            show_mismatch("rx_count", 32'(exp_count), 32'(rx_count));
        for (i = 0; i < exp_count; i++)
        begin
            exp_b = expected_byte(s, i);
            if (rx_bytes[i[1:0]] !== exp_b)
                show_mismatch($sformatf("rx_byte[%0d]", i), 32'(exp_b),
                              32'(rx_bytes[i[1:0]]));
        end
    endtask

    ////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////

    initial
    begin
        axil_req   = '0;
        addr_bits  = 3'd0;
        clr        = 1'b0;
        nack_at    = 3'd4;
        rst_n      = 1'b0;
        mismatches = 0;
        failures   = 0;
        lcg_state  = 32'd95;
        stim_ready = 0;
        load_stimulus();
        stim_ready = 1;
        if (stim_q.size() == 0)
            log_failure("no transactions in the stimulus file");
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        check_idle();
        if (axil_rsp.bvalid !== 1'b0)
            show_mismatch("bvalid", 32'd0, 32'(axil_rsp.bvalid));
        if (axil_rsp.awready !== 1'b0)
            show_mismatch("awready", 32'd0, 32'(axil_rsp.awready));
        foreach (stim_q[k])
        begin
            run_transaction(stim_q[k]);
            check_idle();
        end
        end_run();
    end

    initial
    begin
        longint limit_ns;
        wait (stim_ready);
        // 45 scl periods per transaction plus reset
        limit_ns = longint'(stim_q.size()) * 45 * `I2C_SCL_PERIOD * CLK_PERIOD
                 + 20 * CLK_PERIOD;
        #(limit_ns);
        log_failure("watchdog expired before all transactions finished");
        end_run();
    end

endmodule

/* tests/i2c_stim.txt */
# columns, hex: reg_addr data addr_bits nack_idx bresp
# nack_idx is the refused byte (4 = none), bresp 0 = OKAY, 2 = SLVERR
5a3 c4 5 4 0
000 00 0 4 0
7ff ff 7 4 0
123 5a 2 4 0
6b1 81 3 0 2
2c8 3e 1 1 2
4f0 99 6 2 2
0a7 42 4 3 2
3d5 a5 0 4 0
555 aa 7 4 0

/* compile.f */
+incdir+src
src/i2c_pkg.sv
src/axil_cmd_port.sv
src/scl_timer.sv
src/byte_shifter.sv
src/i2c_write_fsm.sv
src/i2c_reg_writer.sv
tests/i2c_slave_model.sv
tests/tb_i2c_reg_writer.sv

/* Makefile */
TOP := tb_i2c_reg_writer

.PHONY: sim clean

sim:
	verilator --binary --timing -sv -f compile.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "TEST RESULT: FAIL" sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
